// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= runnerTb
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== frameTimer.sv ====
`timescale 1ns/1ns
`default_nettype none

module frameTimer
#(
	parameter int AnimFrames = 10
)
(
	input wire logic frame_Clk,
	input wire logic Reset,
	input gamePkg::gameState_t state,
	output logic [15:0] score,
	output logic animPhase
);

	localparam int CountWidth = $clog2(AnimFrames + 1);

	logic [CountWidth-1:0] frameCount;

	// Score counts frames of play
	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
			score <= '0;
		else if (state == gamePkg::Idle)
			score <= '0;
		else if (state == gamePkg::Running)
			score <= score + 16'd1;
	end

	// Animation runs in every state, phase flips when the count wraps
	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			frameCount <= CountWidth'(1);
			animPhase <= 1'b0;
		end
		else if (frameCount == CountWidth'(AnimFrames))
		begin
			frameCount <= CountWidth'(1);
			animPhase <= ~animPhase;
		end
		else
			frameCount <= frameCount + CountWidth'(1);
	end

endmodule

`default_nettype wire

// ==== gamePkg.sv ====
`default_nettype none

package gamePkg;

	// ==============================
	// Screen and sprite geometry
	// ==============================
	localparam int ScreenWidth = 640;
	localparam int SpriteSize = 20;
	localparam int CoordWidth = 10;
	localparam int RomAddrWidth = 18;

	// ==============================
	// Game flow
	// ==============================
	typedef enum logic [1:0]
	{
		Idle = 2'd0,
		Running = 2'd1,
		Over = 2'd2
	} gameState_t;

	// A signed horizontal position lets the heart slide past the left edge
	typedef logic signed [11:0] pos_t;

endpackage

`default_nettype wire

// ==== gameStateFsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module gameStateFsm
(
	input wire logic frame_Clk,
	input wire logic Reset,
	input wire logic start,
	input wire logic dead,
	output gamePkg::gameState_t state
);

	gamePkg::gameState_t nextState;

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
			state <= gamePkg::Idle;
		else
			state <= nextState;
	end

	// Start restarts from Idle or Over, dead ends a run
	always_comb
	begin
		nextState = state;
		unique case (state)
			gamePkg::Idle:
			begin
				if (start)
					nextState = gamePkg::Running;
			end
			gamePkg::Running:
			begin
				if (dead)
					nextState = gamePkg::Over;
			end
			gamePkg::Over:
			begin
				if (start)
					nextState = gamePkg::Idle;
			end
			default:
				nextState = gamePkg::Idle;
		endcase
	end

endmodule

`default_nettype wire

// ==== heartSprite.sv ====
`timescale 1ns/1ns
`default_nettype none

module heartSprite
#(
	parameter int ScrollSpeed = 4,
	parameter int ScoreModulus = 500,
	parameter int WindowLow = 100,
	parameter int WindowHigh = 150,
	parameter logic [gamePkg::RomAddrWidth-1:0] HeartRomBase0 = 258119,
	parameter logic [gamePkg::RomAddrWidth-1:0] HeartRomBase1 = 258519,
	parameter int HeartRowY = 256
)
(
	input wire logic frame_Clk,
	input wire logic Reset,
	input gamePkg::gameState_t state,
	input wire logic [15:0] score,
	input wire logic animPhase,
	input wire logic [gamePkg::CoordWidth-1:0] obstacleX,
	input wire logic contact,
	input wire logic [gamePkg::CoordWidth-1:0] writeX,
	input wire logic [gamePkg::CoordWidth-1:0] writeY,
	output gamePkg::pos_t heartX,
	output logic heartVisible,
	output logic heartTaken,
	output logic heartOn,
	output logic [gamePkg::RomAddrWidth-1:0] romAddress
);

	localparam gamePkg::pos_t ParkX = gamePkg::pos_t'(gamePkg::ScreenWidth);
	localparam gamePkg::pos_t ExitX = -gamePkg::pos_t'(gamePkg::SpriteSize);
	localparam gamePkg::pos_t Step = gamePkg::pos_t'(ScrollSpeed);

	logic parked;
	logic spawnNow;
	logic [15:0] scoreMod;
	gamePkg::pos_t nextX;
	gamePkg::pos_t distX;
	gamePkg::pos_t distY;
	logic [gamePkg::RomAddrWidth-1:0] phaseBase;

	assign parked = (heartX == ParkX);
	assign heartVisible = !parked && !heartTaken;
	assign nextX = heartX - Step;

	// The heart only launches while the obstacle is on the left half
	assign scoreMod = 16'(score % ScoreModulus);
	assign spawnNow = (scoreMod > WindowLow) && (scoreMod < WindowHigh)
		&& (obstacleX < gamePkg::ScreenWidth / 2);

	// ==============================
	// Position and pickup
	// ==============================
	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			heartX <= ParkX;
			heartTaken <= 1'b0;
		end
		else
		begin
			if (contact)
				heartTaken <= 1'b1;
			if (state == gamePkg::Idle)
			begin
				heartX <= ParkX;
				heartTaken <= 1'b0;
			end
			else if (state == gamePkg::Running)
			begin
				if (parked)
				begin
					if (spawnNow)
						heartX <= ParkX - Step;
				end
				else if (nextX <= ExitX)
				begin
					// Slid fully off the left edge, park and rearm
					heartX <= ParkX;
					heartTaken <= 1'b0;
				end
				else
					heartX <= nextX;
			end
		end
	end

	// ==============================
	// Pixel coverage and ROM address
	// ==============================
	assign distX = gamePkg::pos_t'({2'b00, writeX}) - heartX;
	assign distY = gamePkg::pos_t'({2'b00, writeY}) - gamePkg::pos_t'(HeartRowY);

	// writeX is never negative, so columns left of 0 drop out here
	assign heartOn = heartVisible
		&& (distX >= 0) && (distX < gamePkg::SpriteSize)
		&& (distY >= 0) && (distY < gamePkg::SpriteSize);

	assign phaseBase = animPhase ? HeartRomBase1 : HeartRomBase0;
	assign romAddress = phaseBase
		+ gamePkg::RomAddrWidth'(distY) * gamePkg::RomAddrWidth'(gamePkg::SpriteSize)
		+ gamePkg::RomAddrWidth'(distX);

endmodule

`default_nettype wire

// ==== hitDetect.sv ====
`timescale 1ns/1ns
`default_nettype none

module hitDetect
#(
	parameter int HeartRowY = 256
)
(
	input gamePkg::pos_t heartX,
	input wire logic heartVisible,
	input wire logic [gamePkg::CoordWidth-1:0] playerX,
	input wire logic [gamePkg::CoordWidth-1:0] playerY,
	output logic contact
);

	localparam gamePkg::pos_t Size = gamePkg::pos_t'(gamePkg::SpriteSize);
	localparam gamePkg::pos_t RowY = gamePkg::pos_t'(HeartRowY);

	gamePkg::pos_t px;
	gamePkg::pos_t py;
	logic overlapX;
	logic overlapY;

	assign px = gamePkg::pos_t'({2'b00, playerX});
	assign py = gamePkg::pos_t'({2'b00, playerY});

	// Boxes that only touch at an edge do not count
	assign overlapX = (px < heartX + Size) && (heartX < px + Size);
	assign overlapY = (py < RowY + Size) && (RowY < py + Size);

	assign contact = heartVisible && overlapX && overlapY;

endmodule

`default_nettype wire

// ==== runnerTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module runnerTb;

	localparam int CycleLimit = 3000;
	localparam int ParkX = gamePkg::ScreenWidth;
	localparam int Size = gamePkg::SpriteSize;
	localparam int Speed = 4;
	localparam int RowY = 256;

	logic frame_Clk;
	logic Reset;
	logic start;
	logic dead;
	logic [9:0] obstacleX;
	logic [9:0] playerX;
	logic [9:0] playerY;
	logic [9:0] writeX;
	logic [9:0] writeY;
	gamePkg::gameState_t state;
	logic [15:0] score;
	logic animPhase;
	gamePkg::pos_t heartX;
	logic heartTaken;
	logic contact;
	logic heartOn;
	logic [17:0] romAddress;

	// The reference model of the game advances on the same edges as the DUT
	gamePkg::gameState_t mState;
	int mScore;
	int mFrame;
	logic mPhase;
	int mX;
	logic mTaken;
	int errors = 0;
	int cycles = 0;

	runnerTop i_dut (.*);

	initial frame_Clk = 1'b0;
	always #50 frame_Clk = ~frame_Clk;

	always @(posedge frame_Clk)
	begin
		cycles++;
		if (cycles >= CycleLimit)
		begin
			$display("Timeout after %0d cycles, the tests did not finish", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic hits(int hx, logic taken);
		int px;
		int py;
		px = playerX;
		py = playerY;
		return hx != ParkX && !taken && px < hx + Size && hx < px + Size
			&& py < RowY + Size && RowY < py + Size;
	endfunction

	always @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			mState <= gamePkg::Idle;
			mScore <= 0;
			mFrame <= 0;
			mPhase <= 1'b0;
			mX <= ParkX;
			mTaken <= 1'b0;
		end
		else
		begin
			if (mState == gamePkg::Running && dead)
				mState <= gamePkg::Over;
			else if (mState == gamePkg::Idle && start)
				mState <= gamePkg::Running;
			else if (mState == gamePkg::Over && start)
				mState <= gamePkg::Idle;
			if (mState == gamePkg::Idle)
				mScore <= 0;
			else if (mState == gamePkg::Running)
				mScore <= mScore + 1;
			mFrame <= (mFrame == 9) ? 0 : mFrame + 1;
			if (mFrame == 9)
				mPhase <= ~mPhase;
			if (hits(mX, mTaken))
				mTaken <= 1'b1;
			if (mState == gamePkg::Idle)
			begin
				mX <= ParkX;
				mTaken <= 1'b0;
			end
			else if (mState == gamePkg::Running && mX == ParkX)
			begin
				if (mScore % 500 > 100 && mScore % 500 < 150 && obstacleX < ParkX / 2)
					mX <= ParkX - Speed;
			end
			else if (mState == gamePkg::Running && mX - Speed <= -Size)
			begin
				mX <= ParkX;
				mTaken <= 1'b0;
			end
			else if (mState == gamePkg::Running)
				mX <= mX - Speed;
		end
	end

	task automatic reportMismatch(string what, int got, int exp);
		errors++;
		$display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
	endtask

	task automatic compareModel();
		if (state !== mState)
			reportMismatch("state", state, mState);
		if (score !== 16'(mScore))
			reportMismatch("score", score, mScore);
		if (animPhase !== mPhase)
			reportMismatch("animPhase", animPhase, mPhase);
		if (heartX !== gamePkg::pos_t'(mX))
			reportMismatch("heartX", heartX, mX);
		if (heartTaken !== mTaken)
			reportMismatch("heartTaken", heartTaken, mTaken);
		if (contact !== hits(mX, mTaken))
			reportMismatch("contact", contact, hits(mX, mTaken));
	endtask

	task automatic nextFrame();
		@(posedge frame_Clk);
		#10;
		compareModel();
	endtask

	// Pixel coverage and ROM word for one probe with left columns clipped to 0
	task automatic probePixel(int x, int y);
		int dx;
		int dy;
		int expAddr;
		logic expOn;
		writeX = 10'(x < 0 ? 0 : x);
		writeY = 10'(y);
		#5;
		dx = int'(writeX) - mX;
		dy = y - RowY;
		expOn = mX != ParkX && !mTaken && dx >= 0 && dx < Size && dy >= 0 && dy < Size;
		expAddr = (mPhase ? 258519 : 258119) + dy * Size + dx;
		if (heartOn !== expOn)
			reportMismatch("heartOn", heartOn, expOn);
		if (expOn && romAddress !== 18'(expAddr))
			reportMismatch("romAddress", romAddress, expAddr);
	endtask

	// ==============================
	// Directed tests
	// ==============================
	task automatic idleTest();
		// Player box and probe sit on the parked heart, which must stay hidden
		playerX = 10'(ParkX - 10);
		playerY = 10'(RowY);
		repeat (5)
		begin
			nextFrame();
			probePixel(ParkX + 5, RowY + 5);
		end
		if (state !== gamePkg::Idle)
			reportMismatch("idle state", state, gamePkg::Idle);
		if (score !== 16'd0)
			reportMismatch("idle score", score, 0);
		if (heartX !== gamePkg::pos_t'(ParkX))
			reportMismatch("idle heartX", heartX, ParkX);
		if (contact !== 1'b0)
			reportMismatch("idle contact", contact, 0);
		if (heartOn !== 1'b0)
			reportMismatch("idle heartOn", heartOn, 0);
		playerX = 10'd0;
		playerY = 10'd0;
	endtask

	task automatic startTest();
		int last;
		start = 1'b1;
		nextFrame();
		start = 1'b0;
		if (state !== gamePkg::Running)
			reportMismatch("state after start", state, gamePkg::Running);
		repeat (25)
		begin
			last = score;
			nextFrame();
			if (score !== 16'(last + 1))
				reportMismatch("score step", score, last + 1);
		end
	endtask

	task automatic scrollTest();
		int lastX;
		obstacleX = 10'd100;
		while (score != 16'd101)
		begin
			if (heartX !== gamePkg::pos_t'(ParkX))
				reportMismatch("heartX before spawn", heartX, ParkX);
			nextFrame();
		end
		nextFrame();
		if (heartX !== gamePkg::pos_t'(ParkX - Speed))
			reportMismatch("heartX at spawn", heartX, ParkX - Speed);
		while (heartX != gamePkg::pos_t'(ParkX))
		begin
			lastX = heartX;
			probePixel(lastX - 10 + int'($urandom % 41), RowY - 10 + int'($urandom % 41));
			nextFrame();
			if (heartX != gamePkg::pos_t'(ParkX) && heartX !== gamePkg::pos_t'(lastX - Speed))
				reportMismatch("heartX scroll", heartX, lastX - Speed);
			if (heartX == gamePkg::pos_t'(ParkX) && lastX - Speed > -Size)
				reportMismatch("heartX parked early", lastX, -Size);
		end
	endtask

	task automatic blockedSpawnTest();
		obstacleX = 10'd400;
		while (score != 16'd620)
		begin
			nextFrame();
			if (heartX !== gamePkg::pos_t'(ParkX))
				reportMismatch("heartX with obstacle right", heartX, ParkX);
		end
	endtask

	task automatic pickupTest();
		obstacleX = 10'd100;
		playerX = 10'd300;
		playerY = 10'd250;
		nextFrame();
		if (heartX !== gamePkg::pos_t'(ParkX - Speed))
			reportMismatch("heartX at late spawn", heartX, ParkX - Speed);
		while (contact !== 1'b1)
			nextFrame();
		// First flight position left of the player's right edge
		if (heartX !== gamePkg::pos_t'(316))
			reportMismatch("heartX at contact", heartX, 316);
		nextFrame();
		if (heartTaken !== 1'b1)
			reportMismatch("heartTaken after contact", heartTaken, 1);
		while (heartX != gamePkg::pos_t'(ParkX))
		begin
			probePixel(int'(heartX) + 5, RowY + 8);
			if (heartOn !== 1'b0)
				reportMismatch("heartOn after pickup", heartOn, 0);
			nextFrame();
		end
		if (heartTaken !== 1'b0)
			reportMismatch("heartTaken after park", heartTaken, 0);
		playerY = 10'd0;
	endtask

	task automatic overTest();
		int frozenScore;
		int frozenX;
		while (heartX == gamePkg::pos_t'(ParkX))
			nextFrame();
		repeat (10)
			nextFrame();
		dead = 1'b1;
		nextFrame();
		dead = 1'b0;
		if (state !== gamePkg::Over)
			reportMismatch("state after dead", state, gamePkg::Over);
		frozenScore = score;
		frozenX = heartX;
		repeat (5)
			nextFrame();
		if (score !== 16'(frozenScore))
			reportMismatch("score in Over", score, frozenScore);
		if (heartX !== gamePkg::pos_t'(frozenX))
			reportMismatch("heartX in Over", heartX, frozenX);
		start = 1'b1;
		nextFrame();
		start = 1'b0;
		if (state !== gamePkg::Idle)
			reportMismatch("state after restart", state, gamePkg::Idle);
		nextFrame();
		if (score !== 16'd0)
			reportMismatch("score after restart", score, 0);
		if (heartX !== gamePkg::pos_t'(ParkX))
			reportMismatch("heartX after restart", heartX, ParkX);
	endtask

	initial
	begin
		Reset = 1'b1;
		start = 1'b0;
		dead = 1'b0;
		obstacleX = 10'd400;
		playerX = 10'd0;
		playerY = 10'd0;
		writeX = 10'd0;
		writeY = 10'd0;
		void'($urandom(32'hb769));
		repeat (3)
			@(posedge frame_Clk);
		#10;
		Reset = 1'b0;
		idleTest();
		startTest();
		scrollTest();
		blockedSpawnTest();
		pickupTest();
		overTest();
		$display("Run complete after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== runnerTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module runnerTop
#(
	parameter int AnimFrames = 10,
	parameter int ScrollSpeed = 4,
	parameter int ScoreModulus = 500,
	parameter int WindowLow = 100,
	parameter int WindowHigh = 150,
	parameter logic [gamePkg::RomAddrWidth-1:0] HeartRomBase0 = 258119,
	parameter logic [gamePkg::RomAddrWidth-1:0] HeartRomBase1 = 258519,
	parameter int HeartRowY = 256
)
(
	input wire logic frame_Clk,
	input wire logic Reset,
	input wire logic start,
	input wire logic dead,
	input wire logic [gamePkg::CoordWidth-1:0] obstacleX,
	input wire logic [gamePkg::CoordWidth-1:0] playerX,
	input wire logic [gamePkg::CoordWidth-1:0] playerY,
	input wire logic [gamePkg::CoordWidth-1:0] writeX,
	input wire logic [gamePkg::CoordWidth-1:0] writeY,
	output gamePkg::gameState_t state,
	output logic [15:0] score,
	output logic animPhase,
	output gamePkg::pos_t heartX,
	output logic heartTaken,
	output logic contact,
	output logic heartOn,
	output logic [gamePkg::RomAddrWidth-1:0] romAddress
);

	logic heartVisible;

	gameStateFsm i_gameStateFsm
	(
		.frame_Clk(frame_Clk),
		.Reset(Reset),
		.start(start),
		.dead(dead),
		.state(state)
	);

	frameTimer #(.AnimFrames(AnimFrames)) i_frameTimer
	(
		.frame_Clk(frame_Clk),
		.Reset(Reset),
		.state(state),
		.score(score),
		.animPhase(animPhase)
	);

	heartSprite
	#(
		.ScrollSpeed(ScrollSpeed),
		.ScoreModulus(ScoreModulus),
		.WindowLow(WindowLow),
		.WindowHigh(WindowHigh),
		.HeartRomBase0(HeartRomBase0),
		.HeartRomBase1(HeartRomBase1),
		.HeartRowY(HeartRowY)
	) i_heartSprite
	(
		.frame_Clk(frame_Clk),
		.Reset(Reset),
		.state(state),
		.score(score),
		.animPhase(animPhase),
		.obstacleX(obstacleX),
		.contact(contact),
		.writeX(writeX),
		.writeY(writeY),
		.heartX(heartX),
		.heartVisible(heartVisible),
		.heartTaken(heartTaken),
		.heartOn(heartOn),
		.romAddress(romAddress)
	);

	hitDetect #(.HeartRowY(HeartRowY)) i_hitDetect
	(
		.heartX(heartX),
		.heartVisible(heartVisible),
		.playerX(playerX),
		.playerY(playerY),
		.contact(contact)
	);

endmodule

`default_nettype wire

// ==== runnerTop_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module runnerTopAsserts
(
	input wire logic frame_Clk,
	input wire logic Reset,
	input gamePkg::gameState_t state,
	input wire logic [15:0] score,
	input gamePkg::pos_t heartX,
	input wire logic heartTaken,
	input wire logic heartOn
);

	localparam gamePkg::pos_t ParkX = gamePkg::pos_t'(gamePkg::ScreenWidth);

	takenHidesHeart: assert property (@(posedge frame_Clk) disable iff (Reset)
		!(heartOn && heartTaken))
		else $error("heartOn is high while heartTaken is set");

	scoreHoldsInOver: assert property (@(posedge frame_Clk) disable iff (Reset)
		(state == gamePkg::Over) |=> $stable(score))
		else $error("score changed while the game is over");

	// The heart sits parked for as long as the game is idle
	heartParkedInIdle: assert property (@(posedge frame_Clk) disable iff (Reset)
		(state == gamePkg::Idle) |=> (heartX == ParkX))
		else $error("heartX moved away from the park position in Idle");

	takenUntilParked: assert property (@(posedge frame_Clk) disable iff (Reset)
		heartTaken |=> (heartTaken || heartX == ParkX))
		else $error("heartTaken cleared before the heart parked");

endmodule

bind runnerTop runnerTopAsserts i_asserts
(
	.frame_Clk(frame_Clk),
	.Reset(Reset),
	.state(state),
	.score(score),
	.heartX(heartX),
	.heartTaken(heartTaken),
	.heartOn(heartOn)
);

`default_nettype wire

// ==== src.f ====
gamePkg.sv
gameStateFsm.sv
frameTimer.sv
heartSprite.sv
hitDetect.sv
runnerTop.sv
runnerTop_asserts.sv
runnerTb.sv
